//--- sources.f
eth_pkg.sv
eth_buf_ram.sv
eth_regs.sv
eth_tx.sv
eth_rx.sv
eth_core.sv
tb_eth_core.sv

//--- Bender.yml
package:
  name: eth_core

sources:
  # Shared package
  - eth_pkg.sv
  # RTL
  - files:
      - eth_buf_ram.sv
      - eth_regs.sv
      - eth_tx.sv
      - eth_rx.sv
      - eth_core.sv
  # Testbench
  - target: test
    files:
      - tb_eth_core.sv

//--- tb_eth_core.sv
`timescale 1ns/100ps
`default_nettype none

module tb_eth_core;

   localparam logic [47:0] station_mac = 48'h02_11_22_33_44_55;
   localparam logic [19:0] phy_cycles = 20'd64;
   localparam int bus_limit = 20;
   localparam int wait_limit = 200;

   logic clk = 1'b0;
   logic rst_int;
   logic valid;
   logic [3:0] wstrb;
   logic [11:0] addr;
   logic [31:0] data_in;
   wire ready;
   wire [31:0] data_out;
   wire phy_resetn;
   wire tx_en;
   wire [3:0] tx_data;
   wire rx_dv;
   wire [3:0] rx_data;

   // Direct drive of the receive side, otherwise loopback
   logic direct;
   logic drv_dv;
   logic [3:0] drv_data;

   int unsigned cyc = 0;
   int unsigned last_ready_cyc;
   logic [31:0] rng = 32'h1601_d4cb;
   int n_checks;
   int n_errors;
   int err_mark;
   string test_name;

   // Reference frame model
   logic [7:0] frm [0:2047];
   int frm_len;
   logic [31:0] frm_fcs;
   logic [3:0] exp_nib [$];

   always #50 clk = ~clk;

   always @(posedge clk) begin
      cyc <= cyc + 1;
   end

   assign rx_dv = direct ? drv_dv : tx_en;
   assign rx_data = direct ? drv_data : tx_data;

   eth_core #(.mac_addr(station_mac), .phy_rst_cycles(phy_cycles)) u_dut (
      .clk(clk), .rst_int(rst_int),
      .valid(valid), .wstrb(wstrb), .addr(addr), .data_in(data_in),
      .ready(ready), .data_out(data_out),
      .phy_resetn(phy_resetn), .tx_en(tx_en), .tx_data(tx_data),
      .rx_dv(rx_dv), .rx_data(rx_data)
   );

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] rand_word();
      rng = xorshift32(rng);
      return rng;
   endfunction

   // Bit-serial CRC-32 over the model frame, returns the FCS
   function automatic logic [31:0] model_fcs(input int n);
      logic [31:0] c;
      logic fb;
      c = 32'hFFFF_FFFF;
      for (int i = 0; i < n; i++) begin
         for (int b = 0; b < 8; b++) begin
            fb = c[0] ^ frm[i][b];
            c = {1'b0, c[31:1]};
            if (fb) begin
               c = c ^ 32'hEDB8_8320;
            end
         end
      end
      return ~c;
   endfunction

   // Frame bytes followed by the FCS, low byte first
   function automatic logic [7:0] wire_byte(input int k);
      if (k < frm_len) begin
         return frm[k];
      end
      return frm_fcs[8*(k-frm_len) +: 8];
   endfunction

   function automatic logic [11:0] data_addr(input int w);
      logic [11:0] a;
      a = 12'h800;
      a[10:2] = w[8:0];
      return a;
   endfunction

   task automatic compare_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
      n_checks++;
      if (got !== exp) begin
         $display("[FAIL] %s: got %h, expected %h", name, got, exp);
         n_errors++;
      end
   endtask

   task automatic note_timeout(input string what);
      $display("Timeout while waiting for %s", what);
      n_errors++;
   endtask

   task automatic start_test(input string name);
      test_name = name;
      err_mark = n_errors;
   endtask

   task automatic finish_test;
      $display("[done] %s: %0d error(s)", test_name, n_errors - err_mark);
   endtask

   // Hold the request through the ready cycle so the write lands
   task automatic bus_write(input logic [11:0] a, input logic [31:0] d);
      int t;
      valid = 1'b1;
      wstrb = 4'hF;
      addr = a;
      data_in = d;
      t = 0;
      @(negedge clk);
      while (!ready && t < bus_limit) begin
         @(negedge clk);
         t++;
      end
      if (ready) begin
         last_ready_cyc = cyc;
      end else begin
         note_timeout("ready on a bus write");
      end
      @(negedge clk);
      valid = 1'b0;
      wstrb = 4'h0;
   endtask

   task automatic bus_read(input logic [11:0] a, output logic [31:0] d);
      int t;
      valid = 1'b1;
      wstrb = 4'h0;
      addr = a;
      data_in = 32'h0;
      d = 32'h0;
      t = 0;
      @(negedge clk);
      while (!ready && t < bus_limit) begin
         @(negedge clk);
         t++;
      end
      if (ready) begin
         d = data_out;
         last_ready_cyc = cyc;
      end else begin
         note_timeout("ready on a bus read");
      end
      @(negedge clk);
      valid = 1'b0;
   endtask

   // Random frame to dest, plus the expected nibble stream
   task automatic build_frame(input logic [47:0] dest, input int n);
      logic [31:0] r;
      logic [7:0] b;
      for (int i = 0; i < 6; i++) begin
         frm[i] = dest[47 - 8*i -: 8];
      end
      for (int i = 6; i < n; i++) begin
         r = rand_word();
         frm[i] = r[7:0];
      end
      frm_len = n;
      frm_fcs = model_fcs(n);
      exp_nib.delete();
      for (int i = 0; i < 8; i++) begin
         b = (i == 7) ? eth_pkg::sfd_byte : eth_pkg::preamble_byte;
         exp_nib.push_back(b[3:0]);
         exp_nib.push_back(b[7:4]);
      end
      for (int i = 0; i < n + 4; i++) begin
         b = wire_byte(i);
         exp_nib.push_back(b[3:0]);
         exp_nib.push_back(b[7:4]);
      end
   endtask

   task automatic drive_stream;
      for (int i = 0; i < exp_nib.size(); i++) begin
         drv_dv = 1'b1;
         drv_data = exp_nib[i];
         @(negedge clk);
      end
      drv_dv = 1'b0;
      drv_data = 4'h0;
   endtask

   task automatic wait_rx_state(input logic level, input int limit, output logic reached);
      int t;
      t = 0;
      while (u_dut.rx_data_rcvd !== level && t < limit) begin
         @(negedge clk);
         t++;
      end
      reached = (u_dut.rx_data_rcvd === level);
   endtask

   task automatic check_rx_status(input logic exp_ok, input int exp_count);
      logic [31:0] rd;
      bus_read(eth_pkg::reg_status, rd);
      compare_value("status rx_data_rcvd", rd[eth_pkg::stat_rx_rcvd], 1);
      compare_value("status crc_ok", rd[eth_pkg::stat_crc_ok], exp_ok);
      compare_value("status rx byte count",
                    rd[eth_pkg::stat_nbytes_msb:eth_pkg::stat_nbytes_lsb], exp_count);
   endtask

   task automatic release_frame;
      logic reached;
      logic [31:0] rd;
      bus_write(eth_pkg::reg_rcvack, 32'h0);
      wait_rx_state(1'b0, bus_limit, reached);
      if (!reached) begin
         note_timeout("rx_data_rcvd to clear after the acknowledge");
      end
      bus_read(eth_pkg::reg_status, rd);
      compare_value("status rx_data_rcvd", rd[eth_pkg::stat_rx_rcvd], 0);
   endtask

   task automatic reset_defaults;
      int unsigned rel;
      int t;
      logic [31:0] rd;
      start_test("reset_defaults");
      repeat (3) @(negedge clk);
      rst_int = 1'b0;
      rel = cyc;
      compare_value("ready", ready, 0);
      compare_value("tx_en", tx_en, 0);
      compare_value("rx_data_rcvd", u_dut.rx_data_rcvd, 0);
      compare_value("phy_resetn", phy_resetn, 0);
      // PHY still in reset, so tx_ready is masked
      bus_read(eth_pkg::reg_status, rd);
      compare_value("status", rd, 32'h0);
      t = 0;
      while (!phy_resetn && t < wait_limit) begin
         @(negedge clk);
         t++;
      end
      if (!phy_resetn) begin
         note_timeout("phy_resetn to rise");
      end else begin
         compare_value("phy_resetn rise cycle", cyc - rel, phy_cycles);
      end
      bus_read(eth_pkg::reg_status, rd);
      compare_value("status", rd,
                    (32'h1 << eth_pkg::stat_tx_ready) | (32'h1 << eth_pkg::stat_phy_resetn));
      finish_test();
   endtask

   task automatic register_access;
      logic [31:0] val;
      logic [31:0] rd;
      start_test("register_access");
      val = rand_word();
      bus_write(eth_pkg::reg_dummy, val);
      bus_read(eth_pkg::reg_dummy, rd);
      compare_value("reg_dummy", rd, val);
      val = rand_word() & 32'h7FF;
      bus_write(eth_pkg::reg_tx_nbytes, val);
      bus_read(eth_pkg::reg_tx_nbytes, rd);
      compare_value("reg_tx_nbytes", rd, val);
      finish_test();
   endtask

   task automatic tx_stream;
      int n;
      int t;
      int unsigned send_cyc;
      int unsigned fall_cyc;
      logic [31:0] w;
      logic [3:0] got [$];
      start_test("tx_stream");
      n = 20 + rand_word() % 41;
      build_frame(station_mac, n);
      for (int i = 0; i < (n + 3) / 4; i++) begin
         w = {frm[4*i+3], frm[4*i+2], frm[4*i+1], frm[4*i]};
         bus_write(data_addr(i), w);
      end
      bus_write(eth_pkg::reg_tx_nbytes, n);
      bus_write(eth_pkg::reg_send, 32'h0);
      send_cyc = last_ready_cyc;
      t = 0;
      while (!tx_en && t < bus_limit) begin
         @(negedge clk);
         t++;
      end
      if (!tx_en) begin
         note_timeout("tx_en to rise after the send");
      end else begin
         compare_value("tx_en delay", cyc - send_cyc, 3);
         t = 0;
         while (tx_en && t < 4096) begin
            got.push_back(tx_data);
            @(negedge clk);
            t++;
         end
         fall_cyc = cyc;
         compare_value("tx_en length", got.size(), 2 * (n + 12));
         for (int i = 0; i < got.size() && i < exp_nib.size(); i++) begin
            compare_value("tx_data", got[i], exp_nib[i]);
         end
         t = 0;
         while (!u_dut.tx_ready && t < wait_limit) begin
            @(negedge clk);
            t++;
         end
         if (!u_dut.tx_ready) begin
            note_timeout("tx_ready after the frame");
         end else begin
            compare_value("tx_ready recovery", cyc - fall_cyc, 2 * eth_pkg::ifg_bytes);
         end
      end
      finish_test();
   endtask

   // Checks the frame that tx_stream looped back
   task automatic loopback_receive;
      logic reached;
      logic [31:0] rd;
      logic [31:0] exp;
      logic [31:0] mask;
      int total;
      start_test("loopback_receive");
      total = frm_len + 4;
      wait_rx_state(1'b1, wait_limit, reached);
      if (!reached) begin
         note_timeout("rx_data_rcvd after the looped frame");
      end else begin
         check_rx_status(1'b1, total);
         for (int w = 0; w < (total + 3) / 4; w++) begin
            bus_read(data_addr(w), rd);
            exp = 32'h0;
            mask = 32'h0;
            for (int b = 0; b < 4; b++) begin
               if (4*w + b < total) begin
                  exp[8*b +: 8] = wire_byte(4*w + b);
                  mask[8*b +: 8] = 8'hFF;
               end
            end
            compare_value("rx buffer word", rd & mask, exp);
         end
         bus_read(eth_pkg::reg_crc, rd);
         compare_value("reg_crc", rd, eth_pkg::crc_residue);
         release_frame();
      end
      finish_test();
   endtask

   task automatic address_filter;
      logic reached;
      logic [31:0] r1;
      logic [31:0] r2;
      logic [47:0] dest;
      int n;
      start_test("address_filter");
      direct = 1'b1;
      r1 = rand_word();
      r2 = rand_word();
      dest = {r1[15:0], r2};
      if (dest == station_mac || dest == 48'hFFFF_FFFF_FFFF) begin
         dest = dest ^ 48'h0000_0000_0100;
      end
      n = 20 + rand_word() % 41;
      build_frame(dest, n);
      drive_stream();
      // Status would be up within 3 cycles of rx_dv falling
      wait_rx_state(1'b1, 10, reached);
      compare_value("rx_data_rcvd on a foreign frame", reached, 0);
      repeat (4) @(negedge clk);
      n = 20 + rand_word() % 41;
      build_frame(48'hFFFF_FFFF_FFFF, n);
      drive_stream();
      wait_rx_state(1'b1, bus_limit, reached);
      if (!reached) begin
         note_timeout("rx_data_rcvd after a broadcast frame");
      end else begin
         check_rx_status(1'b1, n + 4);
         release_frame();
      end
      finish_test();
   endtask

   task automatic corrupted_frame;
      logic reached;
      int n;
      int k;
      int b;
      int idx;
      start_test("corrupted_frame");
      direct = 1'b1;
      n = 20 + rand_word() % 41;
      build_frame(station_mac, n);
      // One payload bit flipped after the FCS is computed
      k = 14 + rand_word() % (n - 14);
      b = rand_word() % 8;
      idx = 16 + 2*k + b / 4;
      exp_nib[idx] = exp_nib[idx] ^ (4'h1 << (b % 4));
      drive_stream();
      wait_rx_state(1'b1, bus_limit, reached);
      if (!reached) begin
         note_timeout("rx_data_rcvd after a corrupted frame");
      end else begin
         check_rx_status(1'b0, n + 4);
         release_frame();
      end
      finish_test();
   endtask

   initial begin
      rst_int = 1'b1;
      valid = 1'b0;
      wstrb = 4'h0;
      addr = 12'h0;
      data_in = 32'h0;
      direct = 1'b0;
      drv_dv = 1'b0;
      drv_data = 4'h0;
      n_checks = 0;
      n_errors = 0;
      reset_defaults();
      register_access();
      tx_stream();
      loopback_receive();
      address_filter();
      corrupted_frame();
      $display("checks %0d, errors %0d", n_checks, n_errors);
      if (n_errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- eth_core.sv
`timescale 1ns/100ps
`default_nettype none

module eth_core #(
   parameter logic [47:0] mac_addr = 48'h02_00_00_00_00_01,
   parameter logic [19:0] phy_rst_cycles = 20'hFFFFF
) (
   input wire clk,
   input wire rst_int,

   input wire valid,
   input wire [3:0] wstrb,
   input wire [eth_pkg::eth_addr_w-1:0] addr,
   input wire [31:0] data_in,
   output logic ready,
   output logic [31:0] data_out,

   output logic phy_resetn,
   output logic tx_en,
   output logic [3:0] tx_data,
   input wire rx_dv,
   input wire [3:0] rx_data
);

   logic tx_buf_we;
   logic [eth_pkg::buf_addr_w-1:0] tx_buf_waddr;
   logic [31:0] tx_buf_wdata;
   logic [eth_pkg::buf_addr_w-1:0] tx_buf_raddr;
   logic [31:0] tx_buf_rdata;

   logic rx_buf_we;
   logic [eth_pkg::buf_addr_w-1:0] rx_buf_waddr;
   logic [31:0] rx_buf_wdata;
   logic [eth_pkg::buf_addr_w-1:0] rx_buf_raddr;
   logic [31:0] rx_buf_rdata;

   logic send;
   logic [eth_pkg::nbytes_w-1:0] tx_nbytes;
   logic tx_ready;
   logic rcv_ack;
   logic rx_data_rcvd;
   logic crc_ok;
   logic [eth_pkg::nbytes_w-1:0] rx_nbytes;
   logic [31:0] crc_value;

   eth_regs #(.phy_rst_cycles(phy_rst_cycles)) u_regs (
      .clk(clk), .rst_int(rst_int),
      .valid(valid), .wstrb(wstrb), .addr(addr), .data_in(data_in),
      .ready(ready), .data_out(data_out),
      .tx_buf_we(tx_buf_we), .tx_buf_addr(tx_buf_waddr), .tx_buf_wdata(tx_buf_wdata),
      .rx_buf_addr(rx_buf_raddr), .rx_buf_rdata(rx_buf_rdata),
      .send(send), .tx_nbytes(tx_nbytes), .tx_ready(tx_ready), .rcv_ack(rcv_ack),
      .rx_data_rcvd(rx_data_rcvd), .crc_ok(crc_ok), .rx_nbytes(rx_nbytes),
      .crc_value(crc_value), .phy_resetn(phy_resetn)
   );

   eth_buf_ram #(.addr_w(eth_pkg::buf_addr_w), .data_w(32)) u_tx_buf (
      .clk(clk), .w_en(tx_buf_we), .w_addr(tx_buf_waddr), .w_data(tx_buf_wdata),
      .r_addr(tx_buf_raddr), .r_data(tx_buf_rdata)
   );

   eth_buf_ram #(.addr_w(eth_pkg::buf_addr_w), .data_w(32)) u_rx_buf (
      .clk(clk), .w_en(rx_buf_we), .w_addr(rx_buf_waddr), .w_data(rx_buf_wdata),
      .r_addr(rx_buf_raddr), .r_data(rx_buf_rdata)
   );

   eth_tx u_tx (
      .clk(clk), .rst_int(rst_int), .send(send), .nbytes(tx_nbytes), .ready(tx_ready),
      .buf_addr(tx_buf_raddr), .buf_rdata(tx_buf_rdata), .tx_en(tx_en), .tx_data(tx_data)
   );

   eth_rx #(.mac_addr(mac_addr)) u_rx (
      .clk(clk), .rst_int(rst_int), .rx_dv(rx_dv), .rx_data(rx_data), .rcv_ack(rcv_ack),
      .buf_we(rx_buf_we), .buf_addr(rx_buf_waddr), .buf_wdata(rx_buf_wdata),
      .data_rcvd(rx_data_rcvd), .nbytes(rx_nbytes), .crc_value(crc_value), .crc_ok(crc_ok)
   );

endmodule

`default_nettype wire

//--- eth_rx.sv
`timescale 1ns/100ps
`default_nettype none

module eth_rx #(
   parameter logic [47:0] mac_addr = 48'h0
) (
   input wire clk,
   input wire rst_int,
   input wire rx_dv,
   input wire [3:0] rx_data,
   input wire rcv_ack,
   output logic buf_we,
   output logic [eth_pkg::buf_addr_w-1:0] buf_addr,
   output logic [31:0] buf_wdata,
   output logic data_rcvd,
   output logic [eth_pkg::nbytes_w-1:0] nbytes,
   output logic [31:0] crc_value,
   output logic crc_ok
);

   typedef enum logic [2:0] {
      st_wait,
      st_hunt,
      st_addr,
      st_data,
      st_end,
      st_hold
   } state_t;

   state_t state;
   logic [3:0] prev_nib;
   logic [3:0] nib_lo;
   logic hi;
   logic [eth_pkg::nbytes_w-1:0] cnt;
   logic [31:0] word;
   logic [31:0] next_word;
   logic [31:0] crc;
   logic [31:0] crc_rev;
   logic uc_match;
   logic bc_match;
   logic uc_now;
   logic bc_now;
   logic [7:0] rx_byte;
   logic [7:0] mac_byte;
   logic in_frame;
   logic byte_done;

   assign rx_byte = {rx_data, nib_lo};
   assign in_frame = (state == st_addr) || (state == st_data);
   assign byte_done = in_frame & rx_dv & hi;

   // Destination filter, first byte on the wire is the MSB of mac_addr
   assign mac_byte = mac_addr[47 - 8*cnt[2:0] -: 8];
   assign uc_now = uc_match & (rx_byte == mac_byte);
   assign bc_now = bc_match & (rx_byte == 8'hFF);

   always_comb begin
      next_word = word;
      next_word[8*cnt[1:0] +: 8] = rx_byte;
   end

   assign crc_rev = {<<{crc}};

   always_ff @(posedge clk, posedge rst_int) begin
      if (rst_int) begin
         state <= st_wait;
         prev_nib <= 4'h0;
         hi <= 1'b0;
         cnt <= '0;
         crc <= eth_pkg::crc_init;
         uc_match <= 1'b0;
         bc_match <= 1'b0;
         buf_we <= 1'b0;
         data_rcvd <= 1'b0;
         nbytes <= '0;
         crc_value <= 32'h0;
         crc_ok <= 1'b0;
      end else begin
         buf_we <= 1'b0;
         prev_nib <= rx_dv ? rx_data : 4'h0;
         if (in_frame && rx_dv) begin
            hi <= ~hi;
         end
         if (byte_done) begin
            crc <= eth_pkg::crc_next(crc, rx_byte);
            cnt <= cnt + 11'd1;
            buf_we <= (cnt[1:0] == 2'd3);
         end
         case (state)
            st_wait: begin
               if (!rx_dv) begin
                  state <= st_hunt;
               end
            end
            st_hunt: begin
               if (rx_dv && {rx_data, prev_nib} == eth_pkg::sfd_byte) begin
                  state <= st_addr;
                  cnt <= '0;
                  hi <= 1'b0;
                  crc <= eth_pkg::crc_init;
                  uc_match <= 1'b1;
                  bc_match <= 1'b1;
               end
            end
            st_addr: begin
               if (!rx_dv) begin
                  state <= st_wait;
               end else if (byte_done) begin
                  uc_match <= uc_now;
                  bc_match <= bc_now;
                  if (cnt == 11'd5) begin
                     state <= (uc_now || bc_now) ? st_data : st_wait;
                  end
               end
            end
            st_data: begin
               if (!rx_dv) begin
                  // Flush a partly filled last word
                  buf_we <= (cnt[1:0] != 2'd0);
                  state <= st_end;
               end
            end
            st_end: begin
               data_rcvd <= 1'b1;
               nbytes <= cnt;
               crc_value <= crc_rev;
               crc_ok <= (crc_rev == eth_pkg::crc_residue);
               state <= st_hold;
            end
            default: begin
               // Frame held for the CPU
               if (rcv_ack) begin
                  data_rcvd <= 1'b0;
                  state <= st_wait;
               end
            end
         endcase
      end
   end

   // Word assembly, little-endian byte order
   always_ff @(posedge clk) begin
      if (rx_dv && !hi) begin
         nib_lo <= rx_data;
      end
      if (state == st_hunt) begin
         word <= 32'h0;
      end else if (byte_done) begin
         word <= (cnt[1:0] == 2'd3) ? 32'h0 : next_word;
         buf_wdata <= next_word;
         buf_addr <= cnt[eth_pkg::nbytes_w-1:2];
      end else if (state == st_data && !rx_dv) begin
         buf_wdata <= word;
         buf_addr <= cnt[eth_pkg::nbytes_w-1:2];
      end
   end

   a_no_write_on_hold: assert property (
      @(posedge clk) disable iff (rst_int) buf_we |-> !data_rcvd)
      else $error("eth_rx: buffer written while a frame is held");

endmodule

`default_nettype wire

//--- eth_tx.sv
`timescale 1ns/100ps
`default_nettype none

module eth_tx (
   input wire clk,
   input wire rst_int,
   input wire send,
   input wire [eth_pkg::nbytes_w-1:0] nbytes,
   output logic ready,
   output logic [eth_pkg::buf_addr_w-1:0] buf_addr,
   input wire [31:0] buf_rdata,
   output logic tx_en,
   output logic [3:0] tx_data
);

   typedef enum logic [2:0] {
      st_idle,
      st_pre,
      st_data,
      st_fcs,
      st_gap
   } state_t;

   state_t state;
   logic [eth_pkg::nbytes_w-1:0] len;
   logic [eth_pkg::nbytes_w-1:0] cnt;
   logic [eth_pkg::nbytes_w-1:0] next_idx;
   logic hi;
   logic [31:0] crc;
   logic [7:0] data_byte;
   logic [7:0] cur_byte;

   assign ready = (state == st_idle);

   // Prefetch the word of the byte sent in the next cycle
   assign next_idx = cnt + {{(eth_pkg::nbytes_w-1){1'b0}}, hi};
   assign buf_addr = (state == st_data) ? next_idx[eth_pkg::nbytes_w-1:2] : '0;

   assign data_byte = buf_rdata[8*cnt[1:0] +: 8];

   always_comb begin
      case (state)
         st_pre: cur_byte = (cnt == 11'd7) ? eth_pkg::sfd_byte : eth_pkg::preamble_byte;
         st_data: cur_byte = data_byte;
         st_fcs: cur_byte = ~crc[8*cnt[1:0] +: 8];
         default: cur_byte = 8'h00;
      endcase
   end

   always_ff @(posedge clk, posedge rst_int) begin
      if (rst_int) begin
         state <= st_idle;
         len <= '0;
         cnt <= '0;
         hi <= 1'b0;
         crc <= eth_pkg::crc_init;
         tx_en <= 1'b0;
         tx_data <= 4'h0;
      end else begin
         // Low nibble first
         tx_en <= (state == st_pre) || (state == st_data) || (state == st_fcs);
         tx_data <= hi ? cur_byte[7:4] : cur_byte[3:0];
         case (state)
            st_idle: begin
               if (send) begin
                  state <= st_pre;
                  len <= nbytes;
                  cnt <= '0;
                  hi <= 1'b0;
                  crc <= eth_pkg::crc_init;
               end
            end
            st_pre: begin
               hi <= ~hi;
               if (hi && cnt == 11'd7) begin
                  cnt <= '0;
                  state <= (len == '0) ? st_fcs : st_data;
               end else if (hi) begin
                  cnt <= cnt + 11'd1;
               end
            end
            st_data: begin
               hi <= ~hi;
               if (hi) begin
                  crc <= eth_pkg::crc_next(crc, data_byte);
                  if (cnt == len - 11'd1) begin
                     cnt <= '0;
                     state <= st_fcs;
                  end else begin
                     cnt <= cnt + 11'd1;
                  end
               end
            end
            st_fcs: begin
               hi <= ~hi;
               if (hi && cnt == 11'd3) begin
                  cnt <= '0;
                  state <= st_gap;
               end else if (hi) begin
                  cnt <= cnt + 11'd1;
               end
            end
            default: begin
               // Interframe gap counted in nibbles
               if (cnt == 11'(2 * eth_pkg::ifg_bytes)) begin
                  state <= st_idle;
               end else begin
                  cnt <= cnt + 11'd1;
               end
            end
         endcase
      end
   end

   a_send_when_idle: assert property (
      @(posedge clk) disable iff (rst_int) send |-> state == st_idle)
      else $error("eth_tx: send while a frame is in progress");

endmodule

`default_nettype wire

//--- eth_regs.sv
`timescale 1ns/100ps
`default_nettype none

module eth_regs #(
   parameter logic [19:0] phy_rst_cycles = 20'hFFFFF
) (
   input wire clk,
   input wire rst_int,

   input wire valid,
   input wire [3:0] wstrb,
   input wire [eth_pkg::eth_addr_w-1:0] addr,
   input wire [31:0] data_in,
   output logic ready,
   output logic [31:0] data_out,

   output logic tx_buf_we,
   output logic [eth_pkg::buf_addr_w-1:0] tx_buf_addr,
   output logic [31:0] tx_buf_wdata,

   output logic [eth_pkg::buf_addr_w-1:0] rx_buf_addr,
   input wire [31:0] rx_buf_rdata,

   output logic send,
   output logic [eth_pkg::nbytes_w-1:0] tx_nbytes,
   input wire tx_ready,
   output logic rcv_ack,

   input wire rx_data_rcvd,
   input wire crc_ok,
   input wire [eth_pkg::nbytes_w-1:0] rx_nbytes,
   input wire [31:0] crc_value,

   output logic phy_resetn
);

   logic wr_acc;
   logic is_data;
   logic [31:0] dummy;
   logic [31:0] status;
   logic [19:0] phy_rst_cnt;

   // One ready pulse per transfer
   always_ff @(posedge clk, posedge rst_int) begin
      if (rst_int) begin
         ready <= 1'b0;
      end else begin
         ready <= valid & ~ready;
      end
   end

   assign wr_acc = valid & ready & (|wstrb);
   assign is_data = addr[eth_pkg::eth_addr_w-1];

   // Buffer region is word addressed
   assign tx_buf_we = wr_acc & is_data;
   assign tx_buf_addr = addr[eth_pkg::eth_addr_w-2:2];
   assign tx_buf_wdata = data_in;
   assign rx_buf_addr = addr[eth_pkg::eth_addr_w-2:2];

   always_ff @(posedge clk, posedge rst_int) begin
      if (rst_int) begin
         tx_nbytes <= 11'd46;
         dummy <= 32'h0;
         send <= 1'b0;
         rcv_ack <= 1'b0;
      end else begin
         // Send only while the transmitter and the PHY are up
         send <= wr_acc & (addr == eth_pkg::reg_send) & tx_ready & phy_resetn;
         rcv_ack <= wr_acc & (addr == eth_pkg::reg_rcvack);
         if (wr_acc && addr == eth_pkg::reg_tx_nbytes) begin
            tx_nbytes <= data_in[eth_pkg::nbytes_w-1:0];
         end
         if (wr_acc && addr == eth_pkg::reg_dummy) begin
            dummy <= data_in;
         end
      end
   end

   always_comb begin
      status = 32'h0;
      status[eth_pkg::stat_tx_ready] = tx_ready & phy_resetn;
      status[eth_pkg::stat_rx_rcvd] = rx_data_rcvd;
      status[eth_pkg::stat_crc_ok] = crc_ok;
      status[eth_pkg::stat_phy_resetn] = phy_resetn;
      status[eth_pkg::stat_nbytes_msb:eth_pkg::stat_nbytes_lsb] = rx_nbytes;
   end

   // Read mux
   always_comb begin
      case (addr)
         eth_pkg::reg_status: data_out = status;
         eth_pkg::reg_crc: data_out = crc_value;
         eth_pkg::reg_dummy: data_out = dummy;
         eth_pkg::reg_tx_nbytes: data_out = {21'h0, tx_nbytes};
         default: data_out = is_data ? rx_buf_rdata : 32'h0;
      endcase
   end

   // PHY held in reset for phy_rst_cycles after power-up
   always_ff @(posedge clk, posedge rst_int) begin
      if (rst_int) begin
         phy_rst_cnt <= 20'h0;
         phy_resetn <= 1'b0;
      end else if (phy_rst_cnt == phy_rst_cycles - 20'd1) begin
         phy_resetn <= 1'b1;
      end else begin
         phy_rst_cnt <= phy_rst_cnt + 20'd1;
      end
   end

   a_ready_after_valid: assert property (
      @(posedge clk) disable iff (rst_int) ready |-> valid)
      else $error("eth_regs: ready without a pending valid");

endmodule

`default_nettype wire

//--- eth_buf_ram.sv
`timescale 1ns/100ps
`default_nettype none

module eth_buf_ram #(
   parameter int unsigned addr_w = 9,
   parameter int unsigned data_w = 32
) (
   input wire clk,
   input wire w_en,
   input wire [addr_w-1:0] w_addr,
   input wire [data_w-1:0] w_data,
   input wire [addr_w-1:0] r_addr,
   output logic [data_w-1:0] r_data
);

   logic [data_w-1:0] mem [0:(2**addr_w)-1];

   always_ff @(posedge clk) begin
      if (w_en) begin
         mem[w_addr] <= w_data;
      end
   end

   // Read data lands one cycle after the address
   always_ff @(posedge clk) begin
      r_data <= mem[r_addr];
   end

   a_waddr_known: assert property (@(posedge clk) w_en |-> !$isunknown(w_addr))
      else $error("eth_buf_ram: write with unknown address");

endmodule

`default_nettype wire

//--- eth_pkg.sv
`default_nettype none

package eth_pkg;

   // CPU register port, bit 11 selects the buffer region
   localparam int unsigned eth_addr_w = 12;
   localparam int unsigned nbytes_w = 11;
   localparam int unsigned buf_addr_w = 9;

   localparam logic [eth_addr_w-1:0] reg_status = 12'h000;
   localparam logic [eth_addr_w-1:0] reg_send = 12'h004;
   localparam logic [eth_addr_w-1:0] reg_rcvack = 12'h008;
   localparam logic [eth_addr_w-1:0] reg_tx_nbytes = 12'h00C;
   localparam logic [eth_addr_w-1:0] reg_crc = 12'h010;
   localparam logic [eth_addr_w-1:0] reg_dummy = 12'h014;

   // Status word layout
   localparam int unsigned stat_tx_ready = 0;
   localparam int unsigned stat_rx_rcvd = 1;
   localparam int unsigned stat_crc_ok = 2;
   localparam int unsigned stat_phy_resetn = 3;
   localparam int unsigned stat_nbytes_lsb = 4;
   localparam int unsigned stat_nbytes_msb = 14;

   // Frame constants
   localparam logic [7:0] preamble_byte = 8'h55;
   localparam logic [7:0] sfd_byte = 8'hD5;
   localparam int unsigned ifg_bytes = 12;

   localparam logic [31:0] crc_poly = 32'hEDB88320;
   localparam logic [31:0] crc_init = 32'hFFFFFFFF;
   // Good frame plus FCS leaves this residue, given in MSB-first bit order
   localparam logic [31:0] crc_residue = 32'hC704DD7B;

   // Reflected CRC-32, one byte per call, LSB of the byte first
   function automatic logic [31:0] crc_next(input logic [31:0] crc, input logic [7:0] data);
      logic [31:0] c;
      c = crc ^ {24'h000000, data};
      for (int i = 0; i < 8; i++) begin
         if (c[0]) begin
            c = (c >> 1) ^ crc_poly;
         end else begin
            c = c >> 1;
         end
      end
      return c;
   endfunction

endpackage

`default_nettype wire
